// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_top
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
PASS_MSG   := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: logic/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
    input  logic                clk108_w,
    input  logic                reset_ram_n,
    input  msx_bus_pkg::byte_t  lane_addr_lo,
    input  msx_bus_pkg::byte_t  lane_addr_hi,
    input  msx_bus_pkg::byte_t  lane_ctl,
    input  logic                ctl_ena,
    input  logic                rd_n,
    input  logic                wr_n,
    input  logic                sltsl_n,
    output msx_bus_pkg::addr_t  addr,
    output msx_bus_pkg::byte_t  ctl,
    output logic                slot_sel,
    output logic                rd_act,
    output logic                wr_pulse,
    output logic                vdp_cs,
    output logic                psg_cs,
    output logic                opll_cs
);
    import msx_bus_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // strobe filters, bit 0 rd_n, bit 1 wr_n, bit 2 sltsl_n
    //////////////////////////////////////////////////////////////////////
    logic [2:0] strb_s1;
    logic [2:0] strb_s2;
    logic [2:0] strb_f;
    logic [2:0] agree;
    logic       wr_f_d;       // filtered wr_n, one cycle late
    logic       ctl_ena_d;    // lane outputs are fresh here

    assign agree = ~(strb_s1 ^ strb_s2);

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            strb_s1 <= '1;
            strb_s2 <= '1;
            strb_f  <= '1;
            wr_f_d  <= 1'b1;
        end else begin
            strb_s1 <= {sltsl_n, wr_n, rd_n};
            strb_s2 <= strb_s1;
            strb_f  <= (strb_s2 & agree) | (strb_f & ~agree);
            wr_f_d  <= strb_f[1];
        end
    end

    assign rd_act   = ~strb_f[0];
    assign slot_sel = ~strb_f[2];
    assign wr_pulse = wr_f_d & ~strb_f[1];  // falling edge of filtered wr_n

    // address and control are taken together, after the ctl window
    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            ctl_ena_d <= 1'b0;
            addr      <= '0;
            ctl       <= '1;          // all control lines inactive
        end else begin
            ctl_ena_d <= ctl_ena;
            if (ctl_ena_d) begin
                addr <= {lane_addr_hi, lane_addr_lo};
                ctl  <= lane_ctl;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // i/o chip selects
    //////////////////////////////////////////////////////////////////////
    logic io_cyc;
    assign io_cyc = ~ctl[CTL_IORQ_N] & ctl[CTL_M1_N];   // not an int ack

    assign vdp_cs  = io_cyc && (addr[7:1] == PORT_VDP);
    assign psg_cs  = io_cyc && (addr[7:1] == PORT_PSG);
    assign opll_cs = io_cyc && ~strb_f[1] && (addr[7:1] == PORT_OPLL);   // write only

endmodule

// File: logic/cart_registers.sv
`timescale 1ns/1ps

module cart_registers (
    input  logic                        clk108_w,
    input  logic                        reset_ram_n,
    input  msx_bus_pkg::addr_t          addr,
    input  msx_bus_pkg::byte_t          ctl,
    input  logic                        slot_sel,
    input  logic                        rd_act,
    input  logic                        wr_pulse,
    input  msx_bus_pkg::byte_t          cd_in,
    output msx_bus_pkg::byte_t          cd_out,
    output logic                        datadir,
    output logic                        sd_en,
    output msx_bus_pkg::sector_t        sd_sector,
    output msx_bus_pkg::megaram_type_e  megaram_type,
    output logic                        scc_enable
);
    import msx_bus_pkg::*;

    logic  mem_wr;
    logic  io_wr;
    logic  sd_rd;
    addr_t sec_off;
    logic  sec_hit;

    assign mem_wr = wr_pulse & ~ctl[CTL_MERQ_N] & ctl[CTL_IORQ_N] & ctl[CTL_M1_N];
    assign io_wr  = wr_pulse & ~ctl[CTL_IORQ_N] & ctl[CTL_M1_N]
                    & (addr[7:0] == PORT_MEGARAM);

    assign sec_off   = addr - SDC_SADDR;
    assign sec_hit   = sec_off < addr_t'(4);  // wraps above 7e06 and below 7e03

    //////////////////////////////////////////////////////////////////////
    // sd controller registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            sd_en     <= 1'b0;
            sd_sector <= '0;
        end else if (mem_wr && slot_sel) begin
            if (addr == SDC_ENABLE)
                sd_en <= cd_in[0];
            else if (sd_en && sec_hit)
                sd_sector[8*sec_off[1:0] +: 8] <= cd_in;   // lsb first
        end
    end

    //////////////////////////////////////////////////////////////////////
    // mapper type, i/o port 8f
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            megaram_type <= MEGARAM_KONAMI;
            scc_enable   <= 1'b0;
        end else if (io_wr) begin
            case (cd_in)
                MR_CMD_SCC: begin
                    megaram_type <= MEGARAM_KONAMI_SCC;
                    scc_enable   <= 1'b1;
                end
                MR_CMD_ASCII16: begin
                    megaram_type <= MEGARAM_ASCII16;
                    scc_enable   <= 1'b0;
                end
                MR_CMD_ASCII8: begin
                    megaram_type <= MEGARAM_ASCII8;
                    scc_enable   <= 1'b0;
                end
                default: begin
                    megaram_type <= MEGARAM_KONAMI;
                    scc_enable   <= 1'b0;
                end
            endcase
        end
    end

    // readback, only the enable register is readable here
    assign sd_rd = rd_act & slot_sel & ~ctl[CTL_MERQ_N] & sd_en;

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            cd_out  <= 8'hFF;
            datadir <= 1'b1;        // bus pins as inputs
        end else begin
            datadir <= ~(slot_sel & rd_act);
            if (sd_rd && addr == SDC_ENABLE)
                cd_out <= {7'b0, sd_en};
            else
                cd_out <= 8'hFF;
        end
    end

endmodule

// File: logic/msx_bus_pkg.sv
package msx_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus types
    //////////////////////////////////////////////////////////////////////
    typedef logic [7:0]  byte_t;    // data or pin byte
    typedef logic [15:0] addr_t;    // z80 address
    typedef logic [31:0] sector_t;  // sd sector number
    typedef logic [2:0]  msel_t;    // active-low group select

    typedef enum logic [1:0] {
        MEGARAM_KONAMI     = 2'd0,
        MEGARAM_KONAMI_SCC = 2'd1,
        MEGARAM_ASCII16    = 2'd2,
        MEGARAM_ASCII8     = 2'd3
    } megaram_type_e;

    // mp groups, indexed in sequencer phase order
    localparam int NUM_LANES    = 3;
    localparam int LANE_ADDR_LO = 0;
    localparam int LANE_ADDR_HI = 1;
    localparam int LANE_CTL     = 2;

    localparam msel_t MSEL_ADDR_LO = 3'b110;  // a0-a7
    localparam msel_t MSEL_ADDR_HI = 3'b101;  // a8-a15
    localparam msel_t MSEL_CTL     = 3'b011;  // merq, iorq, .., m1
    localparam msel_t MSEL_NONE    = 3'b111;

    // bit positions in the control byte
    localparam int CTL_MERQ_N = 0;
    localparam int CTL_IORQ_N = 1;
    localparam int CTL_M1_N   = 7;

    //////////////////////////////////////////////////////////////////////
    // i/o ports and cartridge registers
    //////////////////////////////////////////////////////////////////////
    localparam logic [6:0] PORT_VDP  = 7'b1000100;  // 88/89
    localparam logic [6:0] PORT_PSG  = 7'b0100100;  // 48/49
    localparam logic [6:0] PORT_OPLL = 7'b0111110;  // 7c/7d
    localparam byte_t PORT_MEGARAM   = 8'h8F;

    localparam addr_t SDC_ENABLE = 16'h7E00;
    localparam addr_t SDC_SADDR  = 16'h7E03;  // four bytes, lsb first
    localparam addr_t SDC_END    = 16'h7EFF;

    localparam byte_t MR_CMD_SCC     = 8'h05;
    localparam byte_t MR_CMD_ASCII16 = 8'h16;
    localparam byte_t MR_CMD_ASCII8  = 8'h08;

endpackage

// File: logic/msx_bus_top.sv
`timescale 1ns/1ps

module msx_bus_top #(
    parameter int PHASE_CYCLES = 4,
    parameter int FILTER_DEPTH = 2
) (
    input  logic                        clk108_w,
    input  logic                        reset_ram_n,
    input  msx_bus_pkg::byte_t          mp,
    input  msx_bus_pkg::byte_t          cd_in,
    input  logic                        rd_n,
    input  logic                        wr_n,
    input  logic                        sltsl_n,
    output msx_bus_pkg::msel_t          msel_n,
    output msx_bus_pkg::byte_t          cd_out,
    output logic                        datadir,
    output logic                        vdp_cs,
    output logic                        psg_cs,
    output logic                        opll_cs,
    output logic                        sd_en,
    output msx_bus_pkg::sector_t        sd_sector,
    output msx_bus_pkg::megaram_type_e  megaram_type,
    output logic                        scc_enable
);
    import msx_bus_pkg::*;

    logic [NUM_LANES-1:0] lane_ena;
    byte_t                lane_q [NUM_LANES];
    addr_t                addr;
    byte_t                ctl;
    logic                 slot_sel;
    logic                 rd_act;
    logic                 wr_pulse;

    mux_sequencer #(.PHASE_CYCLES(PHASE_CYCLES)) u_seq (
        .clk108_w(clk108_w), .reset_ram_n(reset_ram_n),
        .msel_n(msel_n), .lane_ena(lane_ena)
    );

    // one filter lane per mp group
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        mux_lane #(.FILTER_DEPTH(FILTER_DEPTH)) u_lane (
            .clk108_w(clk108_w), .reset_ram_n(reset_ram_n),
            .pins(mp), .ena(lane_ena[k]), .lane_q(lane_q[k])
        );
    end

    bus_decoder u_dec (
        .clk108_w(clk108_w), .reset_ram_n(reset_ram_n),
        .lane_addr_lo(lane_q[LANE_ADDR_LO]), .lane_addr_hi(lane_q[LANE_ADDR_HI]),
        .lane_ctl(lane_q[LANE_CTL]), .ctl_ena(lane_ena[LANE_CTL]),
        .rd_n(rd_n), .wr_n(wr_n), .sltsl_n(sltsl_n),
        .addr(addr), .ctl(ctl), .slot_sel(slot_sel), .rd_act(rd_act),
        .wr_pulse(wr_pulse), .vdp_cs(vdp_cs), .psg_cs(psg_cs), .opll_cs(opll_cs)
    );

    cart_registers u_regs (
        .clk108_w(clk108_w), .reset_ram_n(reset_ram_n),
        .addr(addr), .ctl(ctl), .slot_sel(slot_sel), .rd_act(rd_act),
        .wr_pulse(wr_pulse), .cd_in(cd_in), .cd_out(cd_out), .datadir(datadir),
        .sd_en(sd_en), .sd_sector(sd_sector),
        .megaram_type(megaram_type), .scc_enable(scc_enable)
    );

endmodule

// File: logic/mux_lane.sv
`timescale 1ns/1ps

module mux_lane #(
    parameter int FILTER_DEPTH = 2
) (
    input  logic                clk108_w,
    input  logic                reset_ram_n,
    input  msx_bus_pkg::byte_t  pins,
    input  logic                ena,
    output msx_bus_pkg::byte_t  lane_q
);
    import msx_bus_pkg::*;

    byte_t samp [FILTER_DEPTH];   // samp[0] is the newest
    byte_t all_hi;
    byte_t all_lo;

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            for (int i = 0; i < FILTER_DEPTH; i++) samp[i] <= '1;
            lane_q <= '1;
        end else begin
            samp[0] <= pins;
            for (int i = 1; i < FILTER_DEPTH; i++) samp[i] <= samp[i-1];
            if (ena) begin
                // glitching bits keep their old value
                lane_q <= all_hi | (lane_q & ~all_lo);
            end
        end
    end

    // per bit agreement over the whole sample chain
    always_comb begin
        all_hi = '1;
        all_lo = '1;
        for (int i = 0; i < FILTER_DEPTH; i++) begin
            all_hi = all_hi & samp[i];
            all_lo = all_lo & ~samp[i];
        end
    end

endmodule

// File: logic/mux_sequencer.sv
`timescale 1ns/1ps

module mux_sequencer #(
    parameter int PHASE_CYCLES = 4
) (
    input  logic                               clk108_w,
    input  logic                               reset_ram_n,
    output msx_bus_pkg::msel_t                 msel_n,
    output logic [msx_bus_pkg::NUM_LANES-1:0]  lane_ena
);
    import msx_bus_pkg::*;

    localparam int CW = (PHASE_CYCLES > 1) ? $clog2(PHASE_CYCLES) : 1;

    logic [CW-1:0] cnt;
    logic [1:0]    phase;     // 0 addr lo, 1 addr hi, 2 ctl, 3 none
    logic          last_cyc;

    function automatic msel_t phase_code(input logic [1:0] ph);
        msel_t code;
        case (ph)
            2'd0:    code = MSEL_ADDR_LO;
            2'd1:    code = MSEL_ADDR_HI;
            2'd2:    code = MSEL_CTL;
            default: code = MSEL_NONE;
        endcase
        return code;
    endfunction

    assign last_cyc = (cnt == CW'(PHASE_CYCLES - 1));

    always_ff @(posedge clk108_w or negedge reset_ram_n) begin
        if (!reset_ram_n) begin
            cnt    <= '0;
            phase  <= 2'd3;         // start idle, addr lo comes next
            msel_n <= MSEL_NONE;
        end else if (last_cyc) begin
            cnt    <= '0;
            phase  <= phase + 2'd1;
            msel_n <= phase_code(phase + 2'd1);
        end else begin
            cnt <= cnt + CW'(1);
        end
    end

    // sample only at the end of a phase, after the external mux has settled
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_ena
        assign lane_ena[k] = last_cyc && (phase == 2'(k));
    end

endmodule

// File: tb.f
+incdir+testbench
logic/msx_bus_pkg.sv
logic/mux_sequencer.sv
logic/mux_lane.sv
logic/bus_decoder.sv
logic/cart_registers.sv
logic/msx_bus_top.sv
testbench/tb_top.sv

// File: testbench/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// bytes the external mux presents, and the register model
addr_t         cur_addr    = 16'hFFFF;
byte_t         cur_ctl     = 8'hFF;
logic          m_sd_en     = 1'b0;
sector_t       m_sd_sector = '0;
megaram_type_e m_mr_type   = MEGARAM_KONAMI;
logic          m_scc       = 1'b0;
logic          opll_seen   = 1'b0;

//////////////////////////////////////////////////////////////////////
// external multiplexer, follows msel_n
//////////////////////////////////////////////////////////////////////
initial begin : mp_responder
    mp = 8'hFF;
    forever begin
        @(negedge clk108_w);
        case (msel_n)
            MSEL_ADDR_LO: mp = cur_addr[7:0];
            MSEL_ADDR_HI: mp = cur_addr[15:8];
            MSEL_CTL:     mp = cur_ctl;
            default:      mp = 8'hFF;     // no group selected
        endcase
    end
end

// returns at the start of the next idle phase
task automatic wait_frame();
    int n;
    n = 0;
    while (msel_n == MSEL_NONE) begin
        @(negedge clk108_w);
        n++;
        if (n > WAIT_LIMIT)
            abort_run("msel_n stuck at the idle code");
    end
    n = 0;
    while (msel_n != MSEL_NONE) begin
        @(negedge clk108_w);
        n++;
        if (n > WAIT_LIMIT)
            abort_run("msel_n never returned to the idle code");
    end
endtask

task automatic set_bus(input addr_t a, input byte_t c);
    cur_addr = a;
    cur_ctl  = c;
    wait_frame();
    wait_frame();
    repeat (2) @(negedge clk108_w);   // addr and ctl load after the ctl window
endtask

function automatic void model_write(input addr_t a, input byte_t c, input byte_t d,
                                    input logic slot);
    int idx;
    idx = int'(a) - 32'h7E03;
    if (slot && !c[CTL_MERQ_N] && c[CTL_IORQ_N] && c[CTL_M1_N]) begin
        if (a == 16'h7E00)
            m_sd_en = d[0];
        else if (m_sd_en && idx >= 0 && idx < 4)
            m_sd_sector[8*idx +: 8] = d;    // byte 0 at 7E03
    end
    if (!c[CTL_IORQ_N] && c[CTL_M1_N] && a[7:0] == 8'h8F) begin
        m_scc = (d == 8'h05);
        if (d == 8'h05)
            m_mr_type = MEGARAM_KONAMI_SCC;
        else if (d == 8'h16)
            m_mr_type = MEGARAM_ASCII16;
        else if (d == 8'h08)
            m_mr_type = MEGARAM_ASCII8;
        else
            m_mr_type = MEGARAM_KONAMI;
    end
endfunction

task automatic bus_write(input addr_t a, input byte_t c, input byte_t d, input logic slot);
    set_bus(a, c);
    cd_in     = d;
    opll_seen = 1'b0;
    wr_n      = 1'b0;
    sltsl_n   = !slot;
    repeat (8) begin
        @(negedge clk108_w);
        opll_seen = opll_seen | opll_cs;
    end
    wr_n    = 1'b1;
    sltsl_n = 1'b1;
    repeat (8) @(negedge clk108_w);
    model_write(a, c, d, slot);
endtask

task automatic bus_read(input addr_t a, input byte_t c, input logic slot,
                        output byte_t d, output logic dd);
    set_bus(a, c);
    rd_n    = 1'b0;
    sltsl_n = !slot;
    repeat (8) @(negedge clk108_w);
    d       = cd_out;                 // settled well after the strobe filter
    dd      = datadir;
    rd_n    = 1'b1;
    sltsl_n = 1'b1;
    repeat (8) @(negedge clk108_w);
endtask

`endif

// File: testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import msx_bus_pkg::*;

    localparam int    WAIT_LIMIT = 64;       // cycles allowed per frame edge
    localparam byte_t IO_CTL     = 8'hFD;    // iorq low, merq and m1 high
    localparam byte_t MEM_CTL    = 8'hFE;    // merq low, iorq and m1 high

    logic          clk108_w;
    logic          reset_ram_n;
    byte_t         mp;
    byte_t         cd_in;
    logic          rd_n;
    logic          wr_n;
    logic          sltsl_n;
    msel_t         msel_n;
    byte_t         cd_out;
    logic          datadir;
    logic          vdp_cs;
    logic          psg_cs;
    logic          opll_cs;
    logic          sd_en;
    sector_t       sd_sector;
    megaram_type_e megaram_type;
    logic          scc_enable;

    integer seed;
    int     errors;
    int     checks;
    int     test_errs;
    int     test_no;

    msx_bus_top #(.PHASE_CYCLES(4), .FILTER_DEPTH(2)) dut (
        .clk108_w(clk108_w), .reset_ram_n(reset_ram_n), .mp(mp), .cd_in(cd_in),
        .rd_n(rd_n), .wr_n(wr_n), .sltsl_n(sltsl_n), .msel_n(msel_n),
        .cd_out(cd_out), .datadir(datadir), .vdp_cs(vdp_cs), .psg_cs(psg_cs),
        .opll_cs(opll_cs), .sd_en(sd_en), .sd_sector(sd_sector),
        .megaram_type(megaram_type), .scc_enable(scc_enable)
    );

    initial begin
        clk108_w = 1'b0;
        forever #10 clk108_w = ~clk108_w;   // 50 MHz
    end

    task automatic abort_run(input string why);
        $display("timeout at %0t ns, %s", $time, why);
        $display("Test failures found");
        $finish;
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        test_no++;
        $display("test %0d %s: %0d mismatches", test_no, name, test_errs);
        test_errs = 0;
    endtask

    `include "tb_bus_tasks.svh"

    task automatic check_regs();
        check("sd_en", 32'(sd_en), 32'(m_sd_en));
        check("sd_sector", sd_sector, m_sd_sector);
        check("megaram_type", 32'(megaram_type), 32'(m_mr_type));
        check("scc_enable", 32'(scc_enable), 32'(m_scc));
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////
    task automatic reset_and_sequence();
        msel_t prev;
        msel_t want;
        int    changes;
        check("datadir", 32'(datadir), 32'(1'b1));
        check("cd_out", 32'(cd_out), 32'hFF);
        check("chip selects", 32'({vdp_cs, psg_cs, opll_cs}), 32'(0));
        check("msel_n", 32'(msel_n), 32'(MSEL_NONE));
        check_regs();
        prev    = msel_n;
        changes = 0;
        repeat (64) begin
            @(negedge clk108_w);
            if (msel_n != prev) begin
                case (prev)     // lo, hi, ctl, then idle
                    MSEL_NONE:    want = MSEL_ADDR_LO;
                    MSEL_ADDR_LO: want = MSEL_ADDR_HI;
                    MSEL_ADDR_HI: want = MSEL_CTL;
                    default:      want = MSEL_NONE;
                endcase
                check("msel_n order", 32'(msel_n), 32'(want));
                changes++;
                prev = msel_n;
            end
        end
        check("msel_n visits all phases", 32'(changes >= 15), 32'(1));
        end_test("reset and sequencer");
    endtask

    task automatic io_chip_selects();
        addr_t a;
        byte_t d;
        int    k;
        repeat (40) begin
            a = 16'($random(seed));
            d = 8'($random(seed));
            k = $unsigned($random(seed)) % 4;   // 3 keeps the random port
            if (k == 0)
                a[7:0] = {PORT_VDP, d[0]};
            else if (k == 1)
                a[7:0] = {PORT_PSG, d[0]};
            else if (k == 2)
                a[7:0] = {PORT_OPLL, d[0]};
            set_bus(a, IO_CTL);
            check("vdp_cs", 32'(vdp_cs), 32'(a[7:1] == 7'b1000100));
            check("psg_cs", 32'(psg_cs), 32'(a[7:1] == 7'b0100100));
            check("opll_cs without write", 32'(opll_cs), 32'(0));
            bus_write(a, IO_CTL, d, 1'b0);
            check("opll_cs during write", 32'(opll_seen), 32'(a[7:1] == 7'b0111110));
        end
        check_regs();
        end_test("i/o chip selects");
    endtask

    task automatic mapper_writes();
        byte_t d;
        int    k;
        repeat (30) begin
            k = $unsigned($random(seed)) % 6;
            d = 8'($random(seed));
            if (k == 0)
                d = MR_CMD_SCC;
            else if (k == 1)
                d = MR_CMD_ASCII16;
            else if (k == 2)
                d = MR_CMD_ASCII8;
            bus_write({8'($random(seed)), 8'h8F}, IO_CTL, d, 1'b0);
            check_regs();
        end
        end_test("mapper type port");
    endtask

    task automatic sd_enable_access();
        byte_t d;
        logic  dd;
        for (int i = 0; i < 4; i++) begin
            d    = 8'($random(seed));
            d[0] = i[0];                    // both values of the enable
            bus_write(16'h7E00, MEM_CTL, d, 1'b1);
            check("sd_en", 32'(sd_en), 32'(m_sd_en));
            bus_read(16'h7E00, MEM_CTL, 1'b1, d, dd);
            check("datadir on read", 32'(dd), 32'(0));
            check("cd_out at 7E00", 32'(d), m_sd_en ? 32'h01 : 32'hFF);
        end
        bus_read(16'h7E00, MEM_CTL, 1'b0, d, dd);
        check("datadir without slot", 32'(dd), 32'(1));
        check("cd_out without slot", 32'(d), 32'hFF);
        end_test("sd enable");
    endtask

    task automatic sector_writes();
        byte_t d;
        logic  dd;
        int    k;
        repeat (16) begin
            k = $unsigned($random(seed)) % 5;   // 4 toggles the enable
            if (k == 4)
                bus_write(16'h7E00, MEM_CTL, 8'($random(seed)), 1'b1);
            else
                bus_write(16'h7E03 + 16'(k), MEM_CTL, 8'($random(seed)), 1'b1);
            check_regs();
        end
        bus_write(16'h7E00, MEM_CTL, 8'h01, 1'b1);
        bus_read(16'h7E03, MEM_CTL, 1'b1, d, dd);
        check("datadir at 7E03", 32'(dd), 32'(0));
        check("cd_out at 7E03", 32'(d), 32'hFF);
        end_test("sector registers");
    endtask

    task automatic mixed_writes();
        addr_t a;
        byte_t d;
        int    k;
        repeat (50) begin
            k = $unsigned($random(seed)) % 4;
            a = 16'($random(seed));
            d = 8'($random(seed));
            case (k)
                0:       bus_write({a[15:8], 8'h8F}, IO_CTL, d, 1'b0);
                1:       bus_write(16'h7E00 + 16'(a[2:0] % 7), MEM_CTL, d, 1'b1);
                2:       bus_write(a, IO_CTL, d, 1'b0);
                default: bus_write(a, MEM_CTL, d, a[0]);
            endcase
            check_regs();
        end
        end_test("mixed writes");
    endtask

    initial begin
        seed        = 32'hfdef4d36;
        errors      = 0;
        checks      = 0;
        test_errs   = 0;
        test_no     = 0;
        reset_ram_n = 1'b0;
        cd_in       = 8'h00;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        sltsl_n     = 1'b1;
        repeat (5) @(negedge clk108_w);
        reset_ram_n = 1'b1;
        reset_and_sequence();
        io_chip_selects();
        mapper_writes();
        sd_enable_access();
        sector_writes();
        mixed_writes();
        $display("summary: %0d tests, %0d checks, %0d errors", test_no, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
